// File: Makefile
# Verilator simulation of the ADC serial capture interface

VERILATOR ?= verilator
TOP       ?= adc_serial_if_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
# parameter overrides, for example GPARAMS="-GTWOLANES=0 -GRESOLUTION=16"
GPARAMS   ?=

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) $(GPARAMS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: flist.f
hdl/adc_if_pkg.sv
hdl/adc_cnv_ctrl.sv
hdl/adc_lane_deser.sv
hdl/adc_sample_buf.sv
hdl/adc_serial_if.sv
sim/adc_serial_if_asserts.sv
sim/adc_serial_if_tb.sv

// File: hdl/adc_cnv_ctrl.sv
`timescale 1ns/1ps

module adc_cnv_ctrl import adc_if_pkg::*; #(
  parameter int RESOLUTION  = 18,
  parameter int TWOLANES    = 1,
  parameter int CONV_CYCLES = 6
) (
  input  logic       s_axi_aclk,
  input  logic       rst,
  input  logic       enable,
  output logic       cnv,
  output logic       clk_gate,
  output logic       lane_shift,
  output logic       word_done,
  output cnv_state_e state
);

  // ------------------------------------------------------------------
  // frame geometry
  // ------------------------------------------------------------------

  // bit clocks per lane for one word
  localparam int lane_bits = RESOLUTION / (TWOLANES + 1);

  // the down-counter covers the longer of the two waits
  localparam int cnt_max = (CONV_CYCLES > lane_bits) ? CONV_CYCLES : lane_bits;
  localparam int cnt_w   = $clog2(cnt_max + 1);

  // reload values, counter runs down to zero inclusive
  localparam logic [cnt_w-1:0] conv_load  = cnt_w'(CONV_CYCLES - 1);
  localparam logic [cnt_w-1:0] shift_load = cnt_w'(lane_bits - 1);

  cnv_state_e       state_nxt;
  logic [cnt_w-1:0] cnt;
  logic [cnt_w-1:0] cnt_nxt;

  // ------------------------------------------------------------------
  // next state
  // ------------------------------------------------------------------

  always_comb begin
    state_nxt = state;
    cnt_nxt   = cnt;
    case (state)
      // a frame only starts from idle with enable set
      st_idle: begin
        if (enable) begin
          state_nxt = st_cnv;
        end
      end
      // single cnv cycle, then arm the conversion wait
      st_cnv: begin
        state_nxt = st_convert;
        cnt_nxt   = conv_load;
      end
      // converter busy, no bit clocks allowed here
      st_convert: begin
        if (cnt == '0) begin
          state_nxt = st_shift;
          cnt_nxt   = shift_load;
        end else begin
          cnt_nxt = cnt - cnt_w'(1);
        end
      end
      // gate open for exactly lane_bits cycles
      st_shift: begin
        if (cnt == '0) begin
          state_nxt = st_done;
        end else begin
          cnt_nxt = cnt - cnt_w'(1);
        end
      end
      // one quiet cycle, then either the next frame or idle
      st_done: begin
        state_nxt = enable ? st_cnv : st_idle;
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  // ------------------------------------------------------------------
  // state and output registers
  // ------------------------------------------------------------------

  always_ff @(posedge s_axi_aclk) begin
    if (rst) begin
      state      <= st_idle;
      cnt        <= '0;
      cnv        <= 1'b0;
      clk_gate   <= 1'b0;
      lane_shift <= 1'b0;
      word_done  <= 1'b0;
    end else begin
      state <= state_nxt;
      cnt   <= cnt_nxt;
      // outputs decoded from next state so they line up with state
      cnv      <= (state_nxt == st_cnv);
      clk_gate <= (state_nxt == st_shift);
      // model drives on the falling edge, so sample one cycle later
      lane_shift <= clk_gate;
      // last lane_shift is the one where the gate has already closed
      word_done <= lane_shift & ~clk_gate;
    end
  end

endmodule

// File: hdl/adc_if_pkg.sv
package adc_if_pkg;

  // ------------------------------------------------------------------
  // width constants
  // ------------------------------------------------------------------

  // widest supported converter resolution
  // narrower samples sit right-aligned in this field
  localparam int sample_w = 18;

  // sample sequence counter, wraps modulo 16
  localparam int seq_w = 4;

  // ------------------------------------------------------------------
  // sample record
  // ------------------------------------------------------------------

  // one converted word plus its sequence tag, 22 bits in all
  typedef struct packed {
    logic [sample_w-1:0] data;
    logic [seq_w-1:0]    seq;
  } adc_sample_t;

  // ------------------------------------------------------------------
  // conversion cycle states
  // ------------------------------------------------------------------

  typedef enum logic [2:0] {
    st_idle    = 3'd0,
    st_cnv     = 3'd1,
    st_convert = 3'd2,
    st_shift   = 3'd3,
    st_done    = 3'd4
  } cnv_state_e;

endpackage

// File: hdl/adc_lane_deser.sv
`timescale 1ns/1ps

module adc_lane_deser import adc_if_pkg::*; #(
  parameter int RESOLUTION = 18,
  parameter int TWOLANES   = 1
) (
  input  logic        s_axi_aclk,
  input  logic        rst,
  input  logic        da,
  input  logic        db,
  input  logic        lane_shift,
  input  logic        word_done,
  output adc_sample_t word,
  output logic        word_valid
);

  // lanes in use and bits carried on each
  localparam int lanes     = TWOLANES + 1;
  localparam int lane_bits = RESOLUTION / lanes;
  // full word as assembled from all lanes
  localparam int word_bits = lane_bits * lanes;

  logic [word_bits-1:0] acc;
  logic [word_bits-1:0] acc_shifted;
  logic [seq_w-1:0]     seq;

  // ------------------------------------------------------------------
  // lane insertion
  // ------------------------------------------------------------------

  // msb first, lane a carries the higher bit of each pair
  if (TWOLANES != 0) begin : g_two_lanes
    assign acc_shifted = {acc[word_bits-3:0], da, db};
  end else begin : g_one_lane
    assign acc_shifted = {acc[word_bits-2:0], da};
  end

  // one step per bit clock of the window
  always_ff @(posedge s_axi_aclk) begin
    if (lane_shift) begin
      acc <= acc_shifted;
    end
  end

  // ------------------------------------------------------------------
  // word capture and sequence tag
  // ------------------------------------------------------------------

  always_ff @(posedge s_axi_aclk) begin
    if (rst) begin
      seq        <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= word_done;
      if (word_done) begin
        // wraps modulo 16, gaps show up downstream on drops
        seq <= seq + seq_w'(1);
      end
    end
  end

  // payload, right-aligned into the sample field
  always_ff @(posedge s_axi_aclk) begin
    if (word_done) begin
      word.data <= sample_w'(acc);
      word.seq  <= seq;
    end
  end

endmodule

// File: hdl/adc_sample_buf.sv
`timescale 1ns/1ps

module adc_sample_buf import adc_if_pkg::*; #(
  parameter int BUF_DEPTH = 4
) (
  input  logic        s_axi_aclk,
  input  logic        rst,
  input  logic        enable,
  input  adc_sample_t word,
  input  logic        word_valid,
  output adc_sample_t sample,
  output logic        sample_valid,
  input  logic        sample_ready,
  output logic        adc_dovf
);

  // pointer and occupancy widths, depth is a power of two
  localparam int ptr_w = $clog2(BUF_DEPTH);
  localparam int cnt_w = ptr_w + 1;

  adc_sample_t      mem [BUF_DEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;

  logic full;
  logic empty;
  logic push;
  logic pop;

  // ------------------------------------------------------------------
  // status and handshake
  // ------------------------------------------------------------------

  assign full  = (count == cnt_w'(BUF_DEPTH));
  assign empty = (count == '0);

  // converter cannot stall, a word at a full buffer is lost
  assign push = word_valid & ~full;
  assign pop  = sample_valid & sample_ready;

  // head of the buffer, held until accepted
  assign sample       = mem[rd_ptr];
  assign sample_valid = ~empty;

  // ------------------------------------------------------------------
  // storage
  // ------------------------------------------------------------------

  always_ff @(posedge s_axi_aclk) begin
    if (push) begin
      mem[wr_ptr] <= word;
    end
  end

  // ------------------------------------------------------------------
  // pointers and occupancy
  // ------------------------------------------------------------------

  always_ff @(posedge s_axi_aclk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + ptr_w'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + ptr_w'(1);
      end
      // simultaneous push and pop leaves the count unchanged
      if (push && !pop) begin
        count <= count + cnt_w'(1);
      end else if (pop && !push) begin
        count <= count - cnt_w'(1);
      end
    end
  end

  // ------------------------------------------------------------------
  // sticky overflow
  // ------------------------------------------------------------------

  // set on any dropped word, cleared once disabled and drained
  always_ff @(posedge s_axi_aclk) begin
    if (rst) begin
      adc_dovf <= 1'b0;
    end else if (word_valid && full) begin
      adc_dovf <= 1'b1;
    end else if (!enable && empty) begin
      adc_dovf <= 1'b0;
    end
  end

endmodule

// File: hdl/adc_serial_if.sv
`timescale 1ns/1ps

module adc_serial_if import adc_if_pkg::*; #(
  parameter int RESOLUTION  = 18,
  parameter int TWOLANES    = 1,
  parameter int CONV_CYCLES = 6,
  parameter int BUF_DEPTH   = 4
) (
  input  logic        s_axi_aclk,
  input  logic        rst,
  input  logic        enable,
  input  logic        da,
  input  logic        db,
  output logic        cnv,
  output logic        clk_gate,
  output adc_sample_t sample,
  output logic        sample_valid,
  input  logic        sample_ready,
  output logic        adc_dovf
);

  // control to deserializer strobes
  logic        lane_shift;
  logic        word_done;
  // fsm state, brought out for the bound checks
  cnv_state_e  ctrl_state;
  // deserializer to buffer
  adc_sample_t word;
  logic        word_valid;

  // ------------------------------------------------------------------
  // conversion cycle control
  // ------------------------------------------------------------------

  adc_cnv_ctrl #(
    .RESOLUTION  (RESOLUTION),
    .TWOLANES    (TWOLANES),
    .CONV_CYCLES (CONV_CYCLES)
  ) adc_cnv_ctrl_i (
    .s_axi_aclk (s_axi_aclk),
    .rst        (rst),
    .enable     (enable),
    .cnv        (cnv),
    .clk_gate   (clk_gate),
    .lane_shift (lane_shift),
    .word_done  (word_done),
    .state      (ctrl_state)
  );

  // ------------------------------------------------------------------
  // lane capture and output buffering
  // ------------------------------------------------------------------

  adc_lane_deser #(
    .RESOLUTION (RESOLUTION),
    .TWOLANES   (TWOLANES)
  ) adc_lane_deser_i (
    .s_axi_aclk (s_axi_aclk),
    .rst        (rst),
    .da         (da),
    .db         (db),
    .lane_shift (lane_shift),
    .word_done  (word_done),
    .word       (word),
    .word_valid (word_valid)
  );

  adc_sample_buf #(
    .BUF_DEPTH (BUF_DEPTH)
  ) adc_sample_buf_i (
    .s_axi_aclk   (s_axi_aclk),
    .rst          (rst),
    .enable       (enable),
    .word         (word),
    .word_valid   (word_valid),
    .sample       (sample),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready),
    .adc_dovf     (adc_dovf)
  );

endmodule

// File: sim/adc_serial_if_asserts.sv
`timescale 1ns/1ps

module adc_serial_if_asserts import adc_if_pkg::*; (
  input logic        s_axi_aclk,
  input logic        rst,
  input logic        cnv,
  input logic        clk_gate,
  input adc_sample_t sample,
  input logic        sample_valid,
  input logic        sample_ready,
  input cnv_state_e  ctrl_state
);

  // running count of assertion failures
  int assert_fails;

  initial assert_fails = 0;

  // ------------------------------------------------------------------
  // conversion cycle
  // ------------------------------------------------------------------

  // conversion start is a single clock wide
  cnv_one_cycle: assert property (@(posedge s_axi_aclk) disable iff (rst)
    $rose(cnv) |=> !cnv)
    else begin
      assert_fails++;
      $error("cnv held high for more than one cycle");
    end

  // no bit clocks while a conversion starts
  gate_not_with_cnv: assert property (@(posedge s_axi_aclk) disable iff (rst)
    !(cnv && clk_gate))
    else begin
      assert_fails++;
      $error("clk_gate high together with cnv");
    end

  // converter busy, gate stays shut
  gate_low_in_convert: assert property (@(posedge s_axi_aclk) disable iff (rst)
    (ctrl_state == st_convert) |-> !clk_gate)
    else begin
      assert_fails++;
      $error("clk_gate high during the convert state");
    end

  // ------------------------------------------------------------------
  // output handshake
  // ------------------------------------------------------------------

  sample_held: assert property (@(posedge s_axi_aclk) disable iff (rst)
    (sample_valid && !sample_ready) |=> (sample_valid && $stable(sample)))
    else begin
      assert_fails++;
      $error("sample changed while stalled");
    end

endmodule

bind adc_serial_if adc_serial_if_asserts adc_serial_if_asserts_i (
  .s_axi_aclk   (s_axi_aclk),
  .rst          (rst),
  .cnv          (cnv),
  .clk_gate     (clk_gate),
  .sample       (sample),
  .sample_valid (sample_valid),
  .sample_ready (sample_ready),
  .ctrl_state   (ctrl_state)
);

// File: sim/adc_serial_if_tb.sv
`timescale 1ns/1ps

module adc_serial_if_tb import adc_if_pkg::*; #(
  parameter int RESOLUTION  = 18,
  parameter int TWOLANES    = 1,
  parameter int CONV_CYCLES = 6,
  parameter int BUF_DEPTH   = 4
);

  // frame geometry as given by the interface timing
  localparam int lane_bits   = RESOLUTION / (TWOLANES + 1);
  localparam int frame_len   = 2 + CONV_CYCLES + lane_bits;
  localparam int n_tests     = 8;
  localparam int cycle_limit = n_tests * 20 * frame_len + 200;

  logic        s_axi_aclk;
  logic        rst;
  logic        enable;
  logic        da;
  logic        db;
  logic        cnv;
  logic        clk_gate;
  adc_sample_t sample;
  logic        sample_valid;
  logic        sample_ready;
  logic        adc_dovf;

  adc_serial_if #(
    .RESOLUTION  (RESOLUTION),
    .TWOLANES    (TWOLANES),
    .CONV_CYCLES (CONV_CYCLES),
    .BUF_DEPTH   (BUF_DEPTH)
  ) adc_serial_if_i (.*);

  // stimulus table
  string               tname   [n_tests];
  logic [sample_w-1:0] tval    [n_tests];
  int                  tframes [n_tests];
  int                  thold   [n_tests];
  logic                tovf    [n_tests];
  logic                tdis    [n_tests];

  // run bookkeeping
  int    cyc;
  int    errors;
  int    test_errs;
  int    passed;
  int    failed;
  string cur_name;
  int    active_seen;

  // requests from the test sequence, applied on the falling edge
  logic                ready_req;
  logic                enable_req;
  logic [sample_w-1:0] seed_val;
  logic                seed_pending;

  // converter model and reference buffer
  logic [31:0]         lcg_state;
  logic [sample_w-1:0] frame_val;
  logic [sample_w-1:0] shreg;
  logic [seq_w-1:0]    sent_seq;
  adc_sample_t         sent_q [$];
  adc_sample_t         ref_q  [$];
  logic                ref_ovf;
  int                  push_wait;
  int                  cnv_count;
  int                  dropped;

  // frame timing monitor
  logic cnv_prev;
  logic gate_prev;
  int   last_cnv;
  int   cnv_at;
  int   gate_len;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // keep only the bits the converter actually delivers
  function automatic logic [sample_w-1:0] res_mask(input logic [sample_w-1:0] v);
    return v & ((sample_w'(1) << RESOLUTION) - sample_w'(1));
  endfunction

  task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("Fail %s: %s expected %0h actual %0h", cur_name, what, exp, act);
    errors++;
    test_errs++;
  endtask

  task automatic problem(input string what);
    $display("%s: %s", cur_name, what);
    errors++;
    test_errs++;
  endtask

  task automatic close_test();
    if (test_errs == 0) begin
      $display("%s: ok", cur_name);
      passed++;
    end else begin
      $display("%s: failed with %0d errors", cur_name, test_errs);
      failed++;
    end
    test_errs = 0;
  endtask

  initial begin
    s_axi_aclk = 1'b0;
    forever #50 s_axi_aclk = ~s_axi_aclk;
  end

  // ------------------------------------------------------------------
  // falling edge: checks, adc model, input drive, reference update
  // ------------------------------------------------------------------

  always @(negedge s_axi_aclk) begin
    adc_sample_t w;
    logic        full_before;
    logic        empty_before;
    logic        drop_now;
    cyc++;
    if (cyc > cycle_limit) begin
      $display("timeout: run exceeded %0d cycles", cycle_limit);
      $display("TEST FAIL");
      $finish;
    end else begin
      rst = (cyc <= 8);
      if (cyc > 8) begin
        // outputs settled since the last rising edge
        if (sample_valid !== (ref_q.size() != 0)) begin
          mismatch("sample_valid", 32'(ref_q.size() != 0), 32'(sample_valid));
        end
        if (adc_dovf !== ref_ovf) begin
          mismatch("adc_dovf", 32'(ref_ovf), 32'(adc_dovf));
        end
        if (cnv || clk_gate || sample_valid || adc_dovf) begin
          active_seen++;
        end
        if (!enable) begin
          last_cnv = -1;
        end
        // new frame, latch the next sample into the model
        if (cnv && !cnv_prev) begin
          cnv_count++;
          if (last_cnv >= 0 && cyc - last_cnv != frame_len) begin
            mismatch("cnv period", 32'(frame_len), 32'(cyc - last_cnv));
          end
          last_cnv = cyc;
          cnv_at   = cyc;
          if (seed_pending) begin
            frame_val    = seed_val;
            seed_pending = 1'b0;
          end
          shreg  = res_mask(frame_val);
          w.data = res_mask(frame_val);
          w.seq  = sent_seq;
          sent_q.push_back(w);
          sent_seq++;
          lcg_state = lcg_next(lcg_state);
          frame_val = lcg_state[25:8];
        end
        // gated bit clock runs one cycle behind its enable
        // msb first on its falling edges, lane b takes the following bit
        if (gate_prev) begin
          da = shreg[RESOLUTION-1];
          db = (TWOLANES != 0) ? shreg[RESOLUTION-2] : 1'b0;
          shreg = shreg << (TWOLANES + 1);
        end
        // gate window position and length
        if (clk_gate) begin
          if (!gate_prev) begin
            gate_len = 0;
            if (cyc - cnv_at != 1 + CONV_CYCLES) begin
              mismatch("cnv to gate delay", 32'(1 + CONV_CYCLES), 32'(cyc - cnv_at));
            end
          end
          gate_len++;
        end else if (gate_prev) begin
          if (gate_len != lane_bits) begin
            mismatch("gate window", 32'(lane_bits), 32'(gate_len));
          end
          // word reaches the buffer three edges after the gate falls
          push_wait = 3;
        end
        cnv_prev  = cnv;
        gate_prev = clk_gate;
      end
      sample_ready = ready_req;
      enable       = enable_req;
      // predict what the next rising edge does to the buffer
      if (cyc > 8) begin
        full_before  = (ref_q.size() == BUF_DEPTH);
        empty_before = (ref_q.size() == 0);
        drop_now     = 1'b0;
        if (!empty_before && sample_ready) begin
          w = ref_q.pop_front();
          if (sample !== w) begin
            mismatch("sample", 32'(w), 32'(sample));
          end
        end
        if (push_wait > 0) begin
          push_wait--;
          if (push_wait == 0) begin
            if (sent_q.size() == 0) begin
              problem("a word completed with no conversion started for it");
            end else begin
              w = sent_q.pop_front();
              if (full_before) begin
                ref_ovf = 1'b1;
                drop_now = 1'b1;
                dropped++;
              end else begin
                ref_q.push_back(w);
              end
            end
          end
        end
        // a drop wins over the clear when both happen on one edge
        if (!drop_now && !enable && empty_before) begin
          ref_ovf = 1'b0;
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------

  initial begin
    int start;
    int drops_before;
    int dis_cnv;
    rst          = 1'b1;
    enable       = 1'b0;
    da           = 1'b0;
    db           = 1'b0;
    sample_ready = 1'b0;
    ready_req    = 1'b1;
    enable_req   = 1'b0;
    seed_pending = 1'b0;
    seed_val     = '0;
    lcg_state    = 32'd96;
    frame_val    = '0;
    shreg        = '0;
    sent_seq     = '0;
    ref_ovf      = 1'b0;
    push_wait    = 0;
    cnv_count    = 0;
    dropped      = 0;
    cnv_prev     = 1'b0;
    gate_prev    = 1'b0;
    last_cnv     = -1;
    cnv_at       = 0;
    gate_len     = 0;
    cyc          = 0;
    errors       = 0;
    test_errs    = 0;
    passed       = 0;
    failed       = 0;
    active_seen  = 0;
    // name, first sample, frames, frames with ready low, overflow, disable
    tname = '{"stream_a", "stream_b", "stream_c", "backpressure",
              "recover", "stream_d", "stream_e", "disable"};
    tframes = '{3, 3, 2, 9, 3, 2, 2, 2};
    thold   = '{0, 0, 0, 7, 0, 0, 0, 0};
    tovf    = '{0, 0, 0, 1, 1, 1, 1, 0};
    tdis    = '{0, 0, 0, 0, 0, 0, 0, 1};
    tval[0] = 18'h3a5a5;
    for (int i = 1; i < n_tests; i++) begin
      lcg_state = lcg_next(lcg_state);
      tval[i]   = lcg_state[25:8];
    end

    // idle after reset, enable held low
    cur_name = "idle";
    repeat (10) @(posedge s_axi_aclk);
    active_seen = 0;
    repeat (20) @(posedge s_axi_aclk);
    if (active_seen != 0) begin
      problem("outputs became active while enable was low");
    end
    close_test();

    for (int i = 0; i < n_tests; i++) begin
      cur_name     = tname[i];
      seed_val     = tval[i];
      seed_pending = 1'b1;
      enable_req   = 1'b1;
      ready_req    = (thold[i] == 0);
      start        = cnv_count;
      drops_before = dropped;
      while (cnv_count - start < tframes[i]) begin
        @(posedge s_axi_aclk);
        if (thold[i] > 0 && cnv_count - start >= thold[i]) begin
          ready_req = 1'b1;
        end
      end
      ready_req = 1'b1;
      if (tdis[i]) begin
        // drop enable in the middle of the bit window
        while (!gate_prev) @(posedge s_axi_aclk);
        enable_req = 1'b0;
        dis_cnv    = cnv_count;
        while (sent_q.size() != 0 || push_wait != 0) @(posedge s_axi_aclk);
        repeat (2 * frame_len) @(posedge s_axi_aclk);
        if (cnv_count != dis_cnv) begin
          problem("conversions continued after enable was lowered");
        end
      end
      while (ref_q.size() != 0) @(posedge s_axi_aclk);
      if (thold[i] > 0 && dropped == drops_before) begin
        problem("no word was dropped while ready was held low");
      end
      @(negedge s_axi_aclk);
      if (adc_dovf !== tovf[i]) begin
        mismatch("overflow flag", 32'(tovf[i]), 32'(adc_dovf));
      end
      @(posedge s_axi_aclk);
      close_test();
    end

    if (adc_serial_if_i.adc_serial_if_asserts_i.assert_fails != 0) begin
      $display("%0d protocol assertion failures during the run",
               adc_serial_if_i.adc_serial_if_asserts_i.assert_fails);
      errors += adc_serial_if_i.adc_serial_if_asserts_i.assert_fails;
    end
    $display("%0d tests passed, %0d failed, %0d errors", passed, failed, errors);
    if (failed == 0 && errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
